// ==== flist.f ====
+incdir+.
vector_io_pkg.sv
ppi_8255.sv
io_port_decode.sv
io_latch_router.sv
kbd_matrix.sv
vector_io_top.sv
tb_vector_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vector I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
	-f flist.f --top-module tb_vector_io -o sim_vector_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_vector_io)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TB PASSED"; then
	exit 0
fi
exit 1

// ==== tb_vector_io.sv ====
`timescale 1ns/1ns
`include "vector_io_defines.svh"

module tb_vector_io;

	localparam logic [31:0] SEED           = 32'hfa44_a6b1;
	localparam int          TEST_CYCLES    = 2000;  // Bound on the length of all tests
	localparam int          TIMEOUT_CYCLES = 2 * TEST_CYCLES;
	localparam logic [7:0]  ADDR_PA        = 8'h00;
	localparam logic [7:0]  ADDR_PB        = 8'h01;
	localparam logic [7:0]  ADDR_PC        = 8'h02;
	localparam logic [7:0]  ADDR_CTRL      = 8'h03;
	localparam logic [7:0]  ADDR_PAL       = 8'h0c;

	logic                      clk24 = 1'b0;
	logic                      mreset;
	logic                      retrace;
	vector_io_pkg::cpu_io_t    cpu;
	vector_io_pkg::key_event_t key;
	vector_io_pkg::io_rdata_t  rdata;
	vector_io_pkg::video_cfg_t video_cfg;
	vector_io_pkg::pal_wr_t    pal_wr;
	logic                      rus_led;

	// Reference model state
	vector_io_pkg::ppi_ports_t m_latch;
	logic [7:0]                m_mode;
	logic [7:0]                m_rowsel;
	logic [7:0]                m_matrix [8];
	logic                      m_shift;
	logic                      m_ctrl;
	logic                      m_rus;
	vector_io_pkg::video_cfg_t exp_video;
	logic [3:0]                exp_paladdr;
	logic                      exp_led;

	vector_io_pkg::io_rdata_t  rd_exp_q [$];   // Pending reads
	string                     rd_name_q [$];
	int                        errors = 0;
	int                        checks = 0;
	int                        cycle_count = 0;

	vector_io_top vector_io_top_inst (
		.clk24     (clk24),
		.mreset    (mreset),
		.cpu       (cpu),
		.key       (key),
		.retrace   (retrace),
		.rdata     (rdata),
		.video_cfg (video_cfg),
		.pal_wr    (pal_wr),
		.rus_led   (rus_led)
	);

	always #2 clk24 = ~clk24;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic void model_ppi_write(input logic [1:0] sel, input logic [7:0] d);
		case (sel)
			`VIO_PPI_PA: m_latch.pa = d;
			`VIO_PPI_PB: m_latch.pb = d;
			`VIO_PPI_PC: m_latch.pc = d;
			default: begin
				if (d[7]) begin           // Mode set clears every latch
					m_mode  = d;
					m_latch = '0;
				end else begin
					m_latch.pc[d[3:1]] = d[0];
				end
			end
		endcase
	endfunction

	// Port outputs as the video and keyboard side see them
	function automatic void model_route();
		exp_led = m_latch.pc[3];
		if (retrace) begin
			m_rowsel    = ~m_latch.pa;
			exp_paladdr = m_latch.pb[3:0];
		end else begin
			exp_video.scroll       = m_latch.pa;
			exp_video.border_index = m_latch.pb[3:0];
			exp_video.mode512      = m_latch.pb[4];
		end
	endfunction

	function automatic logic [7:0] model_port_in(input logic [1:0] sel);
		logic [7:0] rows;
		logic [7:0] val;
		rows = 8'h00;
		for (int r = 0; r < 8; r++) begin
			if (m_rowsel[r]) rows = rows | m_matrix[r];
		end
		case (sel)
			`VIO_PPI_PB: val = ~rows;      // Active low, like the keyboard lines
			`VIO_PPI_PC: val = {~m_rus, ~m_ctrl, ~m_shift, 5'h1f};
			default:     val = 8'hff;
		endcase
		return val;
	endfunction

	function automatic logic [7:0] model_read(input logic [1:0] sel);
		logic [7:0] pin;
		logic [7:0] val;
		pin = model_port_in(sel);
		case (sel)
			`VIO_PPI_PA: val = m_mode[4] ? pin : m_latch.pa;
			`VIO_PPI_PB: val = m_mode[1] ? pin : m_latch.pb;
			`VIO_PPI_PC: begin
				val[7:4] = m_mode[3] ? pin[7:4] : m_latch.pc[7:4];
				val[3:0] = m_mode[0] ? pin[3:0] : m_latch.pc[3:0];
			end
			default: val = m_mode;
		endcase
		return val;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_rdata(input string name, input vector_io_pkg::io_rdata_t exp,
			input vector_io_pkg::io_rdata_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_video(input string name, input vector_io_pkg::video_cfg_t exp,
			input vector_io_pkg::video_cfg_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_pal(input string name, input vector_io_pkg::pal_wr_t exp,
			input vector_io_pkg::pal_wr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_led(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Read results land one cycle after rd
	always @(posedge clk24) begin
		#2;
		if (!mreset && rdata.valid) begin
			if (rd_exp_q.size() == 0) begin
				errors++;
				$display("Read data marked valid while no read was pending");
			end else begin
				check_rdata(rd_name_q.pop_front(), rd_exp_q.pop_front(), rdata);
			end
		end
	end

	always @(posedge clk24) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus master tasks
	////////////////////////////////////////////////////////////////////////////

	// 8255 write, outputs move two cycles after the strobe
	task automatic ppi_write(input string name, input logic [7:0] addr, input logic [7:0] d);
		vector_io_pkg::video_cfg_t prev_video;
		logic                      prev_led;
		prev_video = exp_video;
		prev_led   = exp_led;
		@(posedge clk24);
		#1;
		cpu.addr  = addr;
		cpu.wdata = d;
		cpu.wr    = 1'b1;
		@(posedge clk24);
		#1;
		cpu.wr = 1'b0;
		model_ppi_write(~addr[1:0], d);
		check_video(name, prev_video, video_cfg);   // Not yet routed
		check_led(name, prev_led, rus_led);
		@(posedge clk24);
		#1;
		model_route();
		check_video(name, exp_video, video_cfg);
		check_led(name, exp_led, rus_led);
	endtask

	task automatic pal_write(input string name, input logic [7:0] v);
		vector_io_pkg::pal_wr_t exp_pal;
		@(posedge clk24);
		#1;
		cpu.addr  = ADDR_PAL;
		cpu.wdata = v;
		cpu.wr    = 1'b1;
		@(posedge clk24);
		#1;
		cpu.wr        = 1'b0;
		exp_pal.addr  = exp_paladdr;
		exp_pal.value = v;
		exp_pal.wren  = 1'b1;
		check_pal(name, exp_pal, pal_wr);
		@(posedge clk24);
		#1;
		exp_pal.wren = 1'b0;          // Pulse is one cycle long
		check_pal(name, exp_pal, pal_wr);
	endtask

	task automatic bus_read(input string name, input logic [7:0] addr, input logic [7:0] exp);
		@(posedge clk24);
		#1;
		cpu.addr = addr;
		cpu.rd   = 1'b1;
		rd_exp_q.push_back({exp, 1'b1});
		rd_name_q.push_back(name);
		@(posedge clk24);
		#1;
		cpu.rd = 1'b0;
		while (rd_exp_q.size() != 0) @(posedge clk24);
	endtask

	task automatic key_event(input logic [1:0] kind, input logic [2:0] row,
			input logic [2:0] col, input logic pressed);
		@(posedge clk24);
		#1;
		key.strobe  = 1'b1;
		key.kind    = vector_io_pkg::key_kind_e'(kind);
		key.row     = row;
		key.col     = col;
		key.pressed = pressed;
		@(posedge clk24);
		#1;
		key.strobe = 1'b0;
		case (kind)
			2'd0:    m_matrix[row][col] = pressed;
			2'd1:    m_shift = pressed;
			2'd2:    m_ctrl  = pressed;
			default: m_rus   = pressed;
		endcase
	endtask

	task automatic set_retrace(input logic v);
		@(posedge clk24);
		#1;
		retrace = v;
		@(posedge clk24);
		#1;
		model_route();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		cpu      = '0;
		key      = '0;
		retrace  = 1'b0;
		mreset   = 1'b1;
		m_latch  = '0;
		m_mode   = 8'h9b;             // Mode 0, all ports input
		m_rowsel = 8'h00;
		m_shift  = 1'b0;
		m_ctrl   = 1'b0;
		m_rus    = 1'b0;
		exp_video   = '0;
		exp_paladdr = 4'h0;
		exp_led     = 1'b0;
		for (int r = 0; r < 8; r++) m_matrix[r] = 8'h00;
		repeat (3) @(posedge clk24);
		#1;
		mreset = 1'b0;

		// Reset state
		check_rdata("reset rdata", '0, rdata);
		check_video("reset video", '0, video_cfg);
		check_pal("reset palette", '0, pal_wr);
		check_led("reset led", 1'b0, rus_led);
		bus_read("reset port a", ADDR_PA, model_read(`VIO_PPI_PA));
		bus_read("reset port b", ADDR_PB, model_read(`VIO_PPI_PB));
		bus_read("reset port c", ADDR_PC, model_read(`VIO_PPI_PC));

		// Display latches from port A and B
		ppi_write("mode all out", ADDR_CTRL, 8'h80);
		for (int i = 0; i < 12; i++) begin
			ppi_write("scroll write", ADDR_PA, 8'($urandom()));
			ppi_write("border write", ADDR_PB, 8'($urandom()));
		end

		// Port C bit set/reset and the LED
		ppi_write("led bit set", ADDR_CTRL, 8'h07);
		ppi_write("led bit reset", ADDR_CTRL, 8'h06);
		for (int i = 0; i < 16; i++) begin
			ppi_write("bit set/reset", ADDR_CTRL, {4'b0000, 3'($urandom()), 1'($urandom())});
			bus_read("port c latch", ADDR_PC, model_read(`VIO_PPI_PC));
		end

		// Palette, address from port B under retrace
		set_retrace(1'b1);
		for (int i = 0; i < 6; i++) begin
			ppi_write("palette addr", ADDR_PB, 8'($urandom()));
			pal_write("palette value", 8'($urandom()));
			bus_read("palette port read", ADDR_PAL, `VIO_IDLE_DATA);
			bus_read("unmapped read", 8'h10 | 8'($urandom() % 16), `VIO_IDLE_DATA);
			bus_read("unmapped read", 8'h04 | 8'($urandom() % 4), `VIO_IDLE_DATA);
		end

		// Keyboard scan, port B and upper port C as inputs
		ppi_write("scan mode", ADDR_CTRL, 8'h8a);
		for (int i = 0; i < 10; i++) begin
			repeat (3) begin
				key_event(($urandom() % 3 == 0) ? 2'($urandom()) : 2'd0, 3'($urandom()),
					3'($urandom()), ($urandom() % 4) != 0);
			end
			ppi_write("row select", ADDR_PA, 8'($urandom()));
			bus_read("scan port b", ADDR_PB, model_read(`VIO_PPI_PB));
			bus_read("scan port c", ADDR_PC, model_read(`VIO_PPI_PC));
		end

		// Back to all inputs, latches cleared
		set_retrace(1'b0);
		ppi_write("mode out again", ADDR_CTRL, 8'h80);
		ppi_write("pa before change", ADDR_PA, 8'($urandom()) | 8'h01);
		ppi_write("pb before change", ADDR_PB, 8'($urandom()) | 8'h10);
		ppi_write("pc before change", ADDR_PC, 8'hff);
		ppi_write("mode all in", ADDR_CTRL, 8'h9b);
		bus_read("input port a", ADDR_PA, model_read(`VIO_PPI_PA));
		bus_read("input port b", ADDR_PB, model_read(`VIO_PPI_PB));
		bus_read("input port c", ADDR_PC, model_read(`VIO_PPI_PC));
		bus_read("control read", ADDR_CTRL, model_read(`VIO_PPI_CTRL));

		repeat (2) @(posedge clk24);
		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_count);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== vector_io_top.sv ====
`timescale 1ns/1ns

module vector_io_top (
	input  logic                      clk24,
	input  logic                      mreset,
	input  vector_io_pkg::cpu_io_t    cpu,
	input  vector_io_pkg::key_event_t key,
	input  logic                      retrace,   // 1 while retrace runs
	output vector_io_pkg::io_rdata_t  rdata,
	output vector_io_pkg::video_cfg_t video_cfg,
	output vector_io_pkg::pal_wr_t    pal_wr,
	output logic                      rus_led
);

	logic [1:0]                ppi_reg;
	logic                      ppi_wr;
	logic                      pal_value_wr;
	logic [7:0]                ppi_rdata;
	vector_io_pkg::ppi_ports_t ppi_out;
	vector_io_pkg::ppi_ports_t ppi_in;
	logic [7:0]                kbd_rowselect;

	io_port_decode io_port_decode_inst (
		.clk24        (clk24),
		.mreset       (mreset),
		.cpu          (cpu),
		.ppi_rdata    (ppi_rdata),
		.ppi_reg      (ppi_reg),
		.ppi_wr       (ppi_wr),
		.pal_value_wr (pal_value_wr),
		.rdata        (rdata)
	);

	ppi_8255 ppi_8255_inst (
		.clk24    (clk24),
		.mreset   (mreset),
		.reg_sel  (ppi_reg),
		.wr       (ppi_wr),
		.wdata    (cpu.wdata),
		.port_in  (ppi_in),
		.port_out (ppi_out),
		.rdata    (ppi_rdata)
	);

	io_latch_router io_latch_router_inst (
		.clk24         (clk24),
		.mreset        (mreset),
		.retrace       (retrace),
		.ppi_out       (ppi_out),
		.pal_value_wr  (pal_value_wr),
		.wdata         (cpu.wdata),
		.video_cfg     (video_cfg),
		.pal_wr        (pal_wr),
		.kbd_rowselect (kbd_rowselect),
		.rus_led       (rus_led)
	);

	kbd_matrix kbd_matrix_inst (
		.clk24     (clk24),
		.mreset    (mreset),
		.key       (key),
		.rowselect (kbd_rowselect),
		.ppi_in    (ppi_in)
	);

endmodule

// ==== kbd_matrix.sv ====
`timescale 1ns/1ns

module kbd_matrix (
	input  logic                      clk24,
	input  logic                      mreset,
	input  vector_io_pkg::key_event_t key,
	input  logic [7:0]                rowselect,
	output vector_io_pkg::ppi_ports_t ppi_in
);

	logic [7:0][7:0] matrix;     // [row][col], 1 = key down
	logic            mod_shift;
	logic            mod_ctrl;
	logic            mod_rus;
	logic [7:0]      rowbits;

	always_ff @(posedge clk24) begin
		if (mreset) begin
			matrix    <= '0;
			mod_shift <= 1'b0;
			mod_ctrl  <= 1'b0;
			mod_rus   <= 1'b0;
		end else if (key.strobe) begin
			unique case (key.kind)
				vector_io_pkg::KEY_MATRIX: matrix[key.row][key.col] <= key.pressed;
				vector_io_pkg::KEY_SHIFT:  mod_shift <= key.pressed;
				vector_io_pkg::KEY_CTRL:   mod_ctrl  <= key.pressed;
				vector_io_pkg::KEY_RUS:    mod_rus   <= key.pressed;
			endcase
		end
	end

	// Several rows may be selected at once, their columns merge
	always_comb begin
		rowbits = '0;
		for (int r = 0; r < 8; r++) begin
			if (rowselect[r]) begin
				rowbits = rowbits | matrix[r];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// 8255 inputs, active low like the real machine
	//////////////////////////////////////////////////////////////////////////

	assign ppi_in.pa = 8'hff;                  // Nothing on port A
	assign ppi_in.pb = ~rowbits;
	assign ppi_in.pc = {~mod_rus, ~mod_ctrl, ~mod_shift, 5'b11111};

endmodule

// ==== io_latch_router.sv ====
`timescale 1ns/1ns

module io_latch_router (
	input  logic                      clk24,
	input  logic                      mreset,
	input  logic                      retrace,
	input  vector_io_pkg::ppi_ports_t ppi_out,
	input  logic                      pal_value_wr,
	input  logic [7:0]                wdata,
	output vector_io_pkg::video_cfg_t video_cfg,
	output vector_io_pkg::pal_wr_t    pal_wr,
	output logic [7:0]                kbd_rowselect,
	output logic                      rus_led
);

	//////////////////////////////////////////////////////////////////////////
	// 8255 outputs, meaning depends on retrace
	//////////////////////////////////////////////////////////////////////////

	// During retrace the program scans the keyboard and loads palette
	// addresses, outside of it the same port writes set up the display
	always_ff @(posedge clk24) begin
		if (mreset) begin
			kbd_rowselect <= '0;
			pal_wr.addr   <= '0;
			video_cfg     <= '0;
		end else if (retrace) begin
			kbd_rowselect <= ~ppi_out.pa;          // Rows selected by zeros
			pal_wr.addr   <= ppi_out.pb[3:0];
		end else begin
			video_cfg.scroll       <= ppi_out.pa;
			video_cfg.border_index <= ppi_out.pb[3:0];
			video_cfg.mode512      <= ppi_out.pb[4];
		end
	end

	// RUS/LAT LED on port C bit 3
	always_ff @(posedge clk24) begin
		if (mreset) begin
			rus_led <= 1'b0;
		end else begin
			rus_led <= ppi_out.pc[3];
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Palette value port
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk24) begin
		if (mreset) begin
			pal_wr.value <= '0;
			pal_wr.wren  <= 1'b0;
		end else begin
			pal_wr.wren <= pal_value_wr;           // One-cycle pulse
			if (pal_value_wr) begin
				pal_wr.value <= wdata;
			end
		end
	end

endmodule

// ==== io_port_decode.sv ====
`timescale 1ns/1ns
`include "vector_io_defines.svh"

module io_port_decode (
	input  logic                     clk24,
	input  logic                     mreset,
	input  vector_io_pkg::cpu_io_t   cpu,
	input  logic [7:0]               ppi_rdata,
	output logic [1:0]               ppi_reg,
	output logic                     ppi_wr,
	output logic                     pal_value_wr,
	output vector_io_pkg::io_rdata_t rdata
);

	// Port map, address 000DDDYY
	//   DDD 000  internal 8255
	//   DDD 011  internal ports, YY 00 palette value
	//   others   not present here, read as idle bus
	logic [2:0] device;
	logic       ppi_hit;
	logic       iports_hit;
	logic       pal_hit;

	assign device     = cpu.addr[4:2];
	assign ppi_hit    = (device == `VIO_DEV_PPI);
	assign iports_hit = (device == `VIO_DEV_IPORTS);
	assign pal_hit    = iports_hit & (cpu.addr[1:0] == 2'b00);

	// 8255 registers sit at inverted low address bits
	assign ppi_reg = ~cpu.addr[1:0];

	// Write strobes, taken at the edge closing the wr cycle
	assign ppi_wr       = cpu.wr & ppi_hit;
	assign pal_value_wr = cpu.wr & pal_hit;

	//////////////////////////////////////////////////////////////////////////
	// Registered read data
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk24) begin
		if (mreset) begin
			rdata <= '0;
		end else begin
			rdata.valid <= cpu.rd;          // One cycle after rd
			if (cpu.rd) begin
				if (ppi_hit) begin
					rdata.data <= ppi_rdata;
				end else begin
					rdata.data <= `VIO_IDLE_DATA;   // Palette port is write-only
				end
			end
		end
	end

endmodule

// ==== ppi_8255.sv ====
`timescale 1ns/1ns
`include "vector_io_defines.svh"

module ppi_8255 (
	input  logic                     clk24,
	input  logic                     mreset,
	input  logic [1:0]               reg_sel,
	input  logic                     wr,
	input  logic [7:0]               wdata,
	input  vector_io_pkg::ppi_ports_t port_in,
	output vector_io_pkg::ppi_ports_t port_out,
	output logic [7:0]               rdata
);

	vector_io_pkg::ppi_ctrl_u  ctrl_in;    // Write data seen as control word
	vector_io_pkg::ppi_ctrl_u  mode_word;  // Last mode-set word
	vector_io_pkg::ppi_ports_t latch;      // Output latches
	logic [7:0]                pc_mix;

	assign ctrl_in = wdata;

	//////////////////////////////////////////////////////////////////////////
	// Control word and output latches
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk24) begin
		if (mreset) begin
			mode_word <= 8'h9b;        // Mode 0, every port input
			latch     <= '0;
		end else if (wr) begin
			unique case (reg_sel)
				`VIO_PPI_PA: latch.pa <= wdata;
				`VIO_PPI_PB: latch.pb <= wdata;
				`VIO_PPI_PC: latch.pc <= wdata;
				`VIO_PPI_CTRL: begin
					if (ctrl_in.mode.flag) begin
						// Mode set, group modes kept but only mode 0 runs
						mode_word <= ctrl_in;
						latch     <= '0;
					end else begin
						latch.pc[ctrl_in.bsr.bit_idx] <= ctrl_in.bsr.value;
					end
				end
			endcase
		end
	end

	assign port_out = latch;

	//////////////////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////////////////

	// Port C halves have their own direction
	always_comb begin
		if (mode_word.mode.pcu_in) begin
			pc_mix[7:4] = port_in.pc[7:4];
		end else begin
			pc_mix[7:4] = latch.pc[7:4];
		end
		if (mode_word.mode.pcl_in) begin
			pc_mix[3:0] = port_in.pc[3:0];
		end else begin
			pc_mix[3:0] = latch.pc[3:0];
		end
	end

	always_comb begin
		unique case (reg_sel)
			`VIO_PPI_PA: begin
				if (mode_word.mode.pa_in) begin
					rdata = port_in.pa;
				end else begin
					rdata = latch.pa;
				end
			end
			`VIO_PPI_PB: begin
				if (mode_word.mode.pb_in) begin
					rdata = port_in.pb;
				end else begin
					rdata = latch.pb;
				end
			end
			`VIO_PPI_PC:   rdata = pc_mix;
			`VIO_PPI_CTRL: rdata = mode_word;   // Mode word read back as written
		endcase
	end

endmodule

// ==== vector_io_pkg.sv ====
package vector_io_pkg;

	// One port access from the bus master
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] wdata;
		logic       wr;     // Single-cycle strobe
		logic       rd;     // Single-cycle strobe
	} cpu_io_t;

	typedef struct packed {
		logic [7:0] data;
		logic       valid;
	} io_rdata_t;

	typedef enum logic [1:0] {
		KEY_MATRIX = 2'd0,
		KEY_SHIFT  = 2'd1,
		KEY_CTRL   = 2'd2,
		KEY_RUS    = 2'd3
	} key_kind_e;

	// Decoded key change, row/col only meaningful for matrix keys
	typedef struct packed {
		logic       strobe;
		key_kind_e  kind;
		logic [2:0] row;
		logic [2:0] col;
		logic       pressed;
	} key_event_t;

	//////////////////////////////////////////////////////////////////////////
	// 8255 control word, bit 7 picks the view
	//////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic       flag;   // 1 for mode set
		logic [1:0] mode_a;
		logic       pa_in;  // 1 = input
		logic       pcu_in;
		logic       mode_b;
		logic       pb_in;
		logic       pcl_in;
	} ppi_mode_t;

	typedef struct packed {
		logic       flag;   // 0 for bit set/reset
		logic [2:0] unused;
		logic [2:0] bit_idx;
		logic       value;
	} ppi_bsr_t;

	typedef union packed {
		ppi_mode_t mode;
		ppi_bsr_t  bsr;
	} ppi_ctrl_u;

	typedef struct packed {
		logic [7:0] pa;
		logic [7:0] pb;
		logic [7:0] pc;
	} ppi_ports_t;

	typedef struct packed {
		logic [7:0] scroll;
		logic [3:0] border_index;
		logic       mode512;
	} video_cfg_t;

	typedef struct packed {
		logic [3:0] addr;
		logic [7:0] value;
		logic       wren;
	} pal_wr_t;

endpackage

// ==== vector_io_defines.svh ====
`ifndef VECTOR_IO_DEFINES_SVH
`define VECTOR_IO_DEFINES_SVH

// Device field, port address bits 4:2
`define VIO_DEV_PPI     3'b000  // Internal 8255
`define VIO_DEV_IPORTS  3'b011  // Internal ports, palette value at 0x0C

// Bus value when nothing answers a read
`define VIO_IDLE_DATA   8'hff

// 8255 register select, taken from ~addr[1:0]
`define VIO_PPI_PA      2'd3
`define VIO_PPI_PB      2'd2
`define VIO_PPI_PC      2'd1
`define VIO_PPI_CTRL    2'd0

`endif
